// File: verilog/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN       = 32;                 // Data and instruction width
    localparam int REG_ADDR_W = 5;                  // x0..x31
    localparam int CSR_ADDR_W = 12;
    localparam int MEM_BE_W   = 4;                  // One enable per byte lane

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_BEQ  = 3'b000;        // Branch conditions
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;         // Load widths
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;          // Store widths
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [2:0] F3_SRL_SRA = 3'b101;     // Shift right, funct7[5] picks arithmetic
    localparam logic [2:0] F3_PRIV    = 3'b000;     // ECALL/EBREAK, no CSR access

    // ALU op is {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {BR_NOOP, BR_EQ, BR_NE, BR_LT, BR_LTU, BR_GE, BR_GEU} br_op_e;
    typedef enum logic [2:0] {LD_LB, LD_LH, LD_LW, LD_LBU, LD_LHU} ld_op_e;
    typedef enum logic [1:0] {ST_SB, ST_SH, ST_SW} st_op_e;

    // Operand routing toward the execute stage
    typedef enum logic [1:0] {
        SRC_REGS,                                   // rs1, rs2
        SRC_RS2IMM_RS1,                             // rs1, imm
        SRC_RS2IMM_RS1PC                            // PC, imm
    } src_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_e;

    typedef struct packed {
        logic       imm;                            // Operand is the 5-bit zimm
        logic [1:0] kind;                           // 01 RW, 10 RS, 11 RC
    } csr_op_t;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;                 // Also the CSR address
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;              // imm[11:5]
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;              // imm[4:0]
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm12;               // Sign bit
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;                 // imm[31:12]
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm20;               // Sign bit
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        alu_op_e               alu_op;
        br_op_e                br_op;
        ld_op_e                ld_op;
        st_op_e                st_op;
        src_sel_e              src_sel;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  use_rs1;             // Register file read ports in use
        logic                  use_rs2;
        logic                  rf_wr;
        logic                  mem_rd;
        logic                  mem_wr;
        logic [MEM_BE_W-1:0]   mem_be;
        logic                  is_ldst;
        logic                  jump;                // JAL and JALR
        logic                  jalr;
        csr_op_t               csr_op;
        logic                  csr_wr;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic [4:0]            csr_imm;             // zimm from the rs1 field
    } dec_word_t;

endpackage

`default_nettype wire

// File: verilog/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
    input  rv_decode_pkg::instr_u            instr_i,
    input  rv_decode_pkg::imm_fmt_e          fmt_i,   // Chosen by the opcode decode
    output logic [rv_decode_pkg::XLEN-1:0]   imm_o
);

    import rv_decode_pkg::*;

    always_comb begin
        case (fmt_i)
            IMM_I: begin
                imm_o = {{(XLEN-12){instr_i.i.imm[11]}},  // Sign extend
                         instr_i.i.imm};
            end
            IMM_S: begin
                imm_o = {{(XLEN-12){instr_i.s.imm_hi[6]}},
                         instr_i.s.imm_hi,
                         instr_i.s.imm_lo};               // Fields split around rs1/rs2
            end
            IMM_B: begin
                imm_o = {{(XLEN-13){instr_i.b.imm12}},
                         instr_i.b.imm12,
                         instr_i.b.imm11,
                         instr_i.b.imm10_5,
                         instr_i.b.imm4_1,
                         1'b0};                           // Halfword aligned offset
            end
            IMM_U: begin
                imm_o = {instr_i.u.imm, {(XLEN-20){1'b0}}};  // Upper 20, low 12 cleared
            end
            IMM_J: begin
                imm_o = {{(XLEN-21){instr_i.j.imm20}},
                         instr_i.j.imm20,
                         instr_i.j.imm19_12,
                         instr_i.j.imm11,
                         instr_i.j.imm10_1,
                         1'b0};                           // Halfword aligned offset
            end
            IMM_SHAMT: begin
                // Shift amount only, funct7 bits stay out of the operand
                imm_o = {{(XLEN-5){1'b0}}, instr_i.i.imm[4:0]};
            end
            default: begin
                imm_o = '0;                               // IMM_NONE
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_decode (
    input  rv_decode_pkg::instr_u    instr_i,
    output rv_decode_pkg::dec_word_t dec_o
);

    import rv_decode_pkg::*;

    dec_word_t       dec_c;                         // Control fields, imm filled in later
    imm_fmt_e        fmt_c;                         // Immediate layout for this opcode
    logic [XLEN-1:0] imm_w;
    logic            rd_nz;                         // Destination is not x0

    assign rd_nz = |instr_i.r.rd;

    rv_imm_gen rv_imm_gen_i (
        .instr_i (instr_i),
        .fmt_i   (fmt_c),
        .imm_o   (imm_w)
    );

    always_comb begin
        dec_c         = '0;                         // All flags low, BR_NOOP, ST_SB
        dec_c.alu_op  = ALU_ADD;
        dec_c.ld_op   = LD_LW;
        dec_c.src_sel = SRC_REGS;
        fmt_c         = IMM_NONE;

        // Register and CSR fields come straight from the word
        dec_c.rs1      = (instr_i.r.opcode == OPC_LUI) ? '0 : instr_i.r.rs1;  // LUI adds to x0
        dec_c.rs2      = instr_i.r.rs2;
        dec_c.rd       = instr_i.r.rd;
        dec_c.csr_addr = instr_i.i.imm;
        dec_c.csr_imm  = instr_i.r.rs1;

        case (instr_i.r.opcode)
            OPC_LUI: begin
                dec_c.src_sel = SRC_RS2IMM_RS1;     // 0 + imm
                dec_c.rf_wr   = rd_nz;
                fmt_c         = IMM_U;
            end
            OPC_AUIPC: begin
                dec_c.src_sel = SRC_RS2IMM_RS1PC;   // PC + imm
                dec_c.rf_wr   = rd_nz;
                fmt_c         = IMM_U;
            end
            OPC_JAL: begin
                dec_c.jump    = 1'b1;
                dec_c.src_sel = SRC_RS2IMM_RS1PC;   // Target is PC + offset
                dec_c.rf_wr   = rd_nz;              // Link register gets PC+4
                fmt_c         = IMM_J;
            end
            OPC_JALR: begin
                dec_c.jump    = 1'b1;
                dec_c.jalr    = 1'b1;               // Target is rs1 + offset
                dec_c.use_rs1 = 1'b1;
                dec_c.src_sel = SRC_RS2IMM_RS1PC;
                dec_c.rf_wr   = rd_nz;
                fmt_c         = IMM_I;
            end
            OPC_BRANCH: begin
                dec_c.use_rs1 = 1'b1;               // Compare rs1 against rs2
                dec_c.use_rs2 = 1'b1;
                fmt_c         = IMM_B;
                case (instr_i.b.funct3)
                    F3_BEQ:  dec_c.br_op = BR_EQ;
                    F3_BNE:  dec_c.br_op = BR_NE;
                    F3_BLT:  dec_c.br_op = BR_LT;
                    F3_BGE:  dec_c.br_op = BR_GE;
                    F3_BLTU: dec_c.br_op = BR_LTU;
                    F3_BGEU: dec_c.br_op = BR_GEU;
                    default: dec_c.br_op = BR_NOOP; // 010/011 reserved
                endcase
            end
            OPC_LOAD: begin
                dec_c.is_ldst = 1'b1;
                dec_c.mem_rd  = 1'b1;
                dec_c.use_rs1 = 1'b1;               // Address base
                dec_c.src_sel = SRC_RS2IMM_RS1;
                dec_c.rf_wr   = rd_nz;
                fmt_c         = IMM_I;
                case (instr_i.i.funct3)
                    F3_LB:   dec_c.ld_op = LD_LB;
                    F3_LH:   dec_c.ld_op = LD_LH;
                    F3_LBU:  dec_c.ld_op = LD_LBU;
                    F3_LHU:  dec_c.ld_op = LD_LHU;
                    default: dec_c.ld_op = LD_LW;   // F3_LW and reserved codes
                endcase
            end
            OPC_STORE: begin
                dec_c.is_ldst = 1'b1;
                dec_c.mem_wr  = 1'b1;
                dec_c.use_rs1 = 1'b1;               // Address base
                dec_c.use_rs2 = 1'b1;               // Store data
                dec_c.src_sel = SRC_RS2IMM_RS1;
                fmt_c         = IMM_S;
                case (instr_i.s.funct3)
                    F3_SB: begin
                        dec_c.st_op  = ST_SB;
                        dec_c.mem_be = 4'b0001;
                    end
                    F3_SH: begin
                        dec_c.st_op  = ST_SH;
                        dec_c.mem_be = 4'b0011;
                    end
                    F3_SW: begin
                        dec_c.st_op  = ST_SW;
                        dec_c.mem_be = 4'b1111;
                    end
                    default: ;                      // Reserved width, no lanes enabled
                endcase
            end
            OPC_OP_IMM: begin
                dec_c.use_rs1 = 1'b1;
                dec_c.src_sel = SRC_RS2IMM_RS1;
                dec_c.rf_wr   = rd_nz;
                if (instr_i.i.funct3 == F3_SRL_SRA) begin
                    // funct7[5] splits SRLI from SRAI
                    dec_c.alu_op = alu_op_e'({instr_i.r.funct7[5], instr_i.r.funct3});
                    fmt_c        = IMM_SHAMT;
                end else begin
                    dec_c.alu_op = alu_op_e'({1'b0, instr_i.i.funct3});  // No SUBI
                    fmt_c        = IMM_I;
                end
            end
            OPC_OP: begin
                dec_c.use_rs1 = 1'b1;
                dec_c.use_rs2 = 1'b1;
                dec_c.rf_wr   = rd_nz;
                dec_c.alu_op  = alu_op_e'({instr_i.r.funct7[5], instr_i.r.funct3});
            end
            OPC_FENCE: ;                            // Treated as a NOP
            OPC_SYSTEM: begin
                dec_c.csr_op  = csr_op_t'(instr_i.i.funct3);
                dec_c.csr_wr  = instr_i.i.funct3 != F3_PRIV;  // ECALL/EBREAK touch no CSR
                dec_c.rf_wr   = rd_nz && (instr_i.i.funct3 != F3_PRIV);  // Old CSR value to rd
                dec_c.use_rs1 = !instr_i.i.funct3[2];  // Immediate forms use zimm
            end
            default: ;
        endcase
    end

    always_comb begin
        dec_o     = dec_c;
        dec_o.imm = imm_w;
    end

endmodule

`default_nettype wire

// File: verilog/rv_decode_hs.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_hs (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     instr_req_i,
    output logic                     instr_ack_o,
    input  rv_decode_pkg::dec_word_t dec_i,      // Combinational decode of the input word
    output rv_decode_pkg::dec_word_t dec_o,
    output logic                     dec_req_o,
    input  logic                     dec_ack_i
);

    import rv_decode_pkg::*;

    logic      full_q;                              // Stage holds an item
    logic      instr_ack_q;
    logic      dec_req_q;
    dec_word_t dec_q;
    logic      accept;                              // Capture this cycle

    // Only take a word when empty and the previous input cycle has closed
    assign accept = !full_q && instr_req_i && !instr_ack_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q      <= 1'b0;
            instr_ack_q <= 1'b0;
            dec_req_q   <= 1'b0;
        end else begin
            if (accept) begin
                full_q <= 1'b1;
            end else if (full_q && !dec_req_q && !dec_ack_i) begin
                full_q <= 1'b0;                     // Output four-phase cycle complete
            end

            if (accept) begin
                instr_ack_q <= 1'b1;
            end else if (!instr_req_i) begin
                instr_ack_q <= 1'b0;                // Source dropped req
            end

            if (accept) begin
                dec_req_q <= 1'b1;                  // Offer downstream with the ack
            end else if (dec_ack_i) begin
                dec_req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_q <= '0;
        end else if (accept) begin
            dec_q <= dec_i;
        end
    end

    assign instr_ack_o = instr_ack_q;
    assign dec_req_o   = dec_req_q;
    assign dec_o       = dec_q;

    // Payload must not move under an open output request
    a_dec_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dec_req_o ##1 dec_req_o |-> $stable(dec_o));

    // Sink has to release ack before a new request
    a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(dec_req_o) |-> !$past(dec_ack_i));

    // No new capture while the previous word is still offered
    a_no_accept_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(instr_ack_o) |-> !$past(dec_req_o));

endmodule

`default_nettype wire

// File: verilog/rv_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     instr_req_i,
    input  rv_decode_pkg::instr_u    instr_i,     // Held stable while instr_req_i is high
    output logic                     instr_ack_o,
    output rv_decode_pkg::dec_word_t dec_o,
    output logic                     dec_req_o,
    input  logic                     dec_ack_i
);

    import rv_decode_pkg::*;

    dec_word_t dec_c;                               // Decode of the word on the input bus

    rv_ctrl_decode rv_ctrl_decode_i (
        .instr_i (instr_i),
        .dec_o   (dec_c)
    );

    rv_decode_hs rv_decode_hs_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .instr_req_i (instr_req_i),
        .instr_ack_o (instr_ack_o),
        .dec_i       (dec_c),
        .dec_o       (dec_o),
        .dec_req_o   (dec_req_o),
        .dec_ack_i   (dec_ack_i)
    );

endmodule

`default_nettype wire

// File: include/tb_decode_vectors.svh
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

// Columns: instruction word, then expected decode word as
// alu, br, ld, st, src, imm, rs1, rs2, rd,
// flags {use_rs1 use_rs2 rf_wr}_{mem_rd mem_wr}_{mem_be}_{is_ldst jump jalr},
// csr_op, csr_wr, csr_addr, csr_imm

typedef struct packed {
    logic [31:0] instr;
    dec_word_t   exp;
} vec_t;

localparam int NUM_VEC = 29;

localparam vec_t VEC_TBL [NUM_VEC] = '{
    '{32'h123450B7, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'h12345000,   // LUI
      5'd0, 5'd3, 5'd1, 12'b001_00_0000_000, 3'd0, 1'b0, 12'h123, 5'd8}},
    '{32'h00001297, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1PC, 32'h00001000, // AUIPC
      5'd0, 5'd0, 5'd5, 12'b001_00_0000_000, 3'd0, 1'b0, 12'h000, 5'd0}},
    '{32'h008000EF, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1PC, 32'h00000008, // JAL
      5'd0, 5'd8, 5'd1, 12'b001_00_0000_010, 3'd0, 1'b0, 12'h008, 5'd0}},
    '{32'h004100E7, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1PC, 32'h00000004, // JALR
      5'd2, 5'd4, 5'd1, 12'b101_00_0000_011, 3'd0, 1'b0, 12'h004, 5'd2}},
    '{32'hFE310EE3, {ALU_ADD, BR_EQ, LD_LW, ST_SB, SRC_REGS, 32'hFFFFFFFC,           // BEQ
      5'd2, 5'd3, 5'd29, 12'b110_00_0000_000, 3'd0, 1'b0, 12'hFE3, 5'd2}},
    '{32'hFE311EE3, {ALU_ADD, BR_NE, LD_LW, ST_SB, SRC_REGS, 32'hFFFFFFFC,
      5'd2, 5'd3, 5'd29, 12'b110_00_0000_000, 3'd0, 1'b0, 12'hFE3, 5'd2}},
    '{32'hFE314EE3, {ALU_ADD, BR_LT, LD_LW, ST_SB, SRC_REGS, 32'hFFFFFFFC,
      5'd2, 5'd3, 5'd29, 12'b110_00_0000_000, 3'd0, 1'b0, 12'hFE3, 5'd2}},
    '{32'hFE315EE3, {ALU_ADD, BR_GE, LD_LW, ST_SB, SRC_REGS, 32'hFFFFFFFC,
      5'd2, 5'd3, 5'd29, 12'b110_00_0000_000, 3'd0, 1'b0, 12'hFE3, 5'd2}},
    '{32'hFE316EE3, {ALU_ADD, BR_LTU, LD_LW, ST_SB, SRC_REGS, 32'hFFFFFFFC,
      5'd2, 5'd3, 5'd29, 12'b110_00_0000_000, 3'd0, 1'b0, 12'hFE3, 5'd2}},
    '{32'hFE317EE3, {ALU_ADD, BR_GEU, LD_LW, ST_SB, SRC_REGS, 32'hFFFFFFFC,
      5'd2, 5'd3, 5'd29, 12'b110_00_0000_000, 3'd0, 1'b0, 12'hFE3, 5'd2}},
    '{32'h00810083, {ALU_ADD, BR_NOOP, LD_LB, ST_SB, SRC_RS2IMM_RS1, 32'h00000008,   // LB
      5'd2, 5'd8, 5'd1, 12'b101_10_0000_100, 3'd0, 1'b0, 12'h008, 5'd2}},
    '{32'h00811083, {ALU_ADD, BR_NOOP, LD_LH, ST_SB, SRC_RS2IMM_RS1, 32'h00000008,
      5'd2, 5'd8, 5'd1, 12'b101_10_0000_100, 3'd0, 1'b0, 12'h008, 5'd2}},
    '{32'h00812083, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'h00000008,
      5'd2, 5'd8, 5'd1, 12'b101_10_0000_100, 3'd0, 1'b0, 12'h008, 5'd2}},
    '{32'h00814083, {ALU_ADD, BR_NOOP, LD_LBU, ST_SB, SRC_RS2IMM_RS1, 32'h00000008,
      5'd2, 5'd8, 5'd1, 12'b101_10_0000_100, 3'd0, 1'b0, 12'h008, 5'd2}},
    '{32'h00815083, {ALU_ADD, BR_NOOP, LD_LHU, ST_SB, SRC_RS2IMM_RS1, 32'h00000008,
      5'd2, 5'd8, 5'd1, 12'b101_10_0000_100, 3'd0, 1'b0, 12'h008, 5'd2}},
    '{32'h00812003, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'h00000008,   // LW x0
      5'd2, 5'd8, 5'd0, 12'b100_10_0000_100, 3'd0, 1'b0, 12'h008, 5'd2}},
    '{32'h00310623, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'h0000000C,   // SB
      5'd2, 5'd3, 5'd12, 12'b110_01_0001_100, 3'd0, 1'b0, 12'h003, 5'd2}},
    '{32'h00311623, {ALU_ADD, BR_NOOP, LD_LW, ST_SH, SRC_RS2IMM_RS1, 32'h0000000C,
      5'd2, 5'd3, 5'd12, 12'b110_01_0011_100, 3'd0, 1'b0, 12'h003, 5'd2}},
    '{32'h00312623, {ALU_ADD, BR_NOOP, LD_LW, ST_SW, SRC_RS2IMM_RS1, 32'h0000000C,
      5'd2, 5'd3, 5'd12, 12'b110_01_1111_100, 3'd0, 1'b0, 12'h003, 5'd2}},
    '{32'hFFF10093, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'hFFFFFFFF,   // ADDI -1
      5'd2, 5'd31, 5'd1, 12'b101_00_0000_000, 3'd0, 1'b0, 12'hFFF, 5'd2}},
    '{32'h00315093, {ALU_SRL, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'h00000003,   // SRLI
      5'd2, 5'd3, 5'd1, 12'b101_00_0000_000, 3'd0, 1'b0, 12'h003, 5'd2}},
    '{32'h40315093, {ALU_SRA, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'h00000003,   // SRAI
      5'd2, 5'd3, 5'd1, 12'b101_00_0000_000, 3'd0, 1'b0, 12'h403, 5'd2}},
    '{32'h00110013, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_RS2IMM_RS1, 32'h00000001,   // ADDI x0
      5'd2, 5'd1, 5'd0, 12'b100_00_0000_000, 3'd0, 1'b0, 12'h001, 5'd2}},
    '{32'h003100B3, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_REGS, 32'h00000000,         // ADD
      5'd2, 5'd3, 5'd1, 12'b111_00_0000_000, 3'd0, 1'b0, 12'h003, 5'd2}},
    '{32'h403100B3, {ALU_SUB, BR_NOOP, LD_LW, ST_SB, SRC_REGS, 32'h00000000,         // SUB
      5'd2, 5'd3, 5'd1, 12'b111_00_0000_000, 3'd0, 1'b0, 12'h403, 5'd2}},
    '{32'h300110F3, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_REGS, 32'h00000000,         // CSRRW
      5'd2, 5'd0, 5'd1, 12'b101_00_0000_000, 3'b001, 1'b1, 12'h300, 5'd2}},
    '{32'h3052E0F3, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_REGS, 32'h00000000,         // CSRRSI
      5'd5, 5'd5, 5'd1, 12'b001_00_0000_000, 3'b110, 1'b1, 12'h305, 5'd5}},
    '{32'h30011073, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_REGS, 32'h00000000,         // CSRRW x0
      5'd2, 5'd0, 5'd0, 12'b100_00_0000_000, 3'b001, 1'b1, 12'h300, 5'd2}},
    '{32'h00000073, {ALU_ADD, BR_NOOP, LD_LW, ST_SB, SRC_REGS, 32'h00000000,         // ECALL
      5'd0, 5'd0, 5'd0, 12'b100_00_0000_000, 3'd0, 1'b0, 12'h000, 5'd0}}
};

`endif

// File: tb/tb_rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder;

    import rv_decode_pkg::*;

    `include "tb_decode_vectors.svh"

    localparam int RST_CYCLES = 16;
    localparam int CLK_NS     = 8;

    logic       clk_i = 1'b0;
    logic       arst_n_i;
    logic       instr_req_i;
    instr_u     instr_i;
    logic       instr_ack_o;
    dec_word_t  dec_o;
    logic       dec_req_o;
    logic       dec_ack_i;
    logic [7:0] lfsr_q = 8'd50;                     // Back-pressure source

    rv_decoder_top rv_decoder_top_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .instr_ack_o (instr_ack_o),
        .dec_o       (dec_o),
        .dec_req_o   (dec_req_o),
        .dec_ack_i   (dec_ack_i)
    );

    always #(CLK_NS / 2) clk_i = ~clk_i;

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};  // Taps 8,6,5,4
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);             // One step per bit
            val    = val * 2 + int'(lfsr_q[0]);
        end
    endtask

    task automatic check_dec(input string name, input dec_word_t exp, input dec_word_t act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "Decode word mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "Handshake bit mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;                                         // Drive and sample off the edge
    endtask

    task automatic check_idle();
        check_bit("instr_ack_o", 1'b0, instr_ack_o);
        check_bit("dec_req_o", 1'b0, dec_req_o);
        check_dec("dec_o", '0, dec_o);
    endtask

    // Sink side, random wait then full four-phase cycle
    task automatic drain_output(input dec_word_t exp);
        int wait_n;
        draw_bits(2, wait_n);
        repeat (wait_n) begin
            next_cycle();
            check_bit("dec_req_o", 1'b1, dec_req_o);
            check_bit("instr_ack_o", 1'b0, instr_ack_o);  // Pending req held off
            check_dec("dec_o", exp, dec_o);
        end
        dec_ack_i = 1'b1;
        next_cycle();
        check_bit("dec_req_o", 1'b0, dec_req_o);    // Drops one cycle after ack
        check_bit("instr_ack_o", 1'b0, instr_ack_o);
        check_dec("dec_o", exp, dec_o);
        dec_ack_i = 1'b0;
        next_cycle();
        check_bit("instr_ack_o", 1'b0, instr_ack_o);  // Stage empties on this edge
    endtask

    initial begin
        arst_n_i    = 1'b0;
        instr_req_i = 1'b0;
        instr_i     = '0;
        dec_ack_i   = 1'b0;
        repeat (RST_CYCLES) begin
            next_cycle();
            check_idle();
        end
        arst_n_i = 1'b1;
        next_cycle();
        check_idle();

        for (int i = 0; i < NUM_VEC; i++) begin
            instr_i     = VEC_TBL[i].instr;
            instr_req_i = 1'b1;
            if (i > 0) begin
                drain_output(VEC_TBL[i-1].exp);     // Previous word still offered
            end
            next_cycle();
            check_bit("instr_ack_o", 1'b1, instr_ack_o);  // One cycle from req in EMPTY
            check_bit("dec_req_o", 1'b1, dec_req_o);
            check_dec("dec_o", VEC_TBL[i].exp, dec_o);
            instr_req_i = 1'b0;
            next_cycle();
            check_bit("instr_ack_o", 1'b0, instr_ack_o);
            check_bit("dec_req_o", 1'b1, dec_req_o);
        end
        drain_output(VEC_TBL[NUM_VEC-1].exp);
        next_cycle();
        check_bit("instr_ack_o", 1'b0, instr_ack_o);
        check_bit("dec_req_o", 1'b0, dec_req_o);

        $display("Test passed");
        $finish;
    end

    // Each vector needs well under 64 cycles
    initial begin
        #((RST_CYCLES + NUM_VEC * 64) * CLK_NS);
        $display("Test failed");
        $fatal(1, "Timeout, the handshake sequence did not finish in time");
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
verilog/rv_decode_pkg.sv
verilog/rv_imm_gen.sv
verilog/rv_ctrl_decode.sv
verilog/rv_decode_hs.sv
verilog/rv_decoder_top.sv
tb/tb_rv_decoder.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_rv_decoder
FILELIST ?= sim.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
